//--- flist.f
cam_display_pkg.sv
vga_timing.sv
display_ctrl.sv
frame_buffer.sv
threshold_ctrl.sv
pixel_path.sv
cam_display_top.sv
tb_cam_display.sv

//--- Makefile
# Verilator build and run of the cam display testbench
VERILATOR  ?= verilator
TOP        ?= tb_cam_display
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_cam_display.sv
`timescale 1ns/1ps

module tb_cam_display;
    import cam_display_pkg::*;

    localparam int RAND_SEED    = 32152;
    localparam int FRAME_CLKS   = H_TOTAL * V_TOTAL;
    localparam int LOAD_CLKS    = 4 * FB_PIXELS;           // four clocks per handshake
    localparam int WATCHDOG_CLK = 7 * FRAME_CLKS + LOAD_CLKS;
    localparam int LIT_FRAMES   = 4;                       // colour, gray and two threshold frames

    logic               clk_25_vga = 1'b0;
    logic               rst_n;
    logic               wr_req;
    logic [ADDR_W-1:0]  wr_addr;
    logic [PIX_W-1:0]   wr_data;
    logic               wr_ack;
    logic               frame_valid;
    logic               btn_thr_up;
    logic               btn_thr_down;
    logic               sw_grayscale;
    logic               sw_threshold;
    logic [COLOR_W-1:0] vga_r;
    logic [COLOR_W-1:0] vga_g;
    logic [COLOR_W-1:0] vga_b;
    logic               vga_hsync;
    logic               vga_vsync;
    logic               vga_blank_n;

    logic [PIX_W-1:0] shadow [0:FB_PIXELS-1];   // copy of what the writer stored
    logic             exp_on    = 1'b0;          // frames expected to show picture
    int               thr_model = THR_INIT;
    int               pos_line  = 0;             // active line at the pins
    int               pos_col   = 0;
    int               cyc       = 0;
    int               hs_last   = -1;
    int               vs_last   = -1;
    int               lit_checked = 0;
    logic             hs_prev    = 1'b1;
    logic             vs_prev    = 1'b1;
    logic             blank_prev = 1'b0;
    logic [23:0]      exp_rgb;

    always #2 clk_25_vga = ~clk_25_vga;   // 4 ns period

    cam_display_top cam_display_top_inst (
        .clk_25_vga   (clk_25_vga),
        .rst_n        (rst_n),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_ack       (wr_ack),
        .frame_valid  (frame_valid),
        .btn_thr_up   (btn_thr_up),
        .btn_thr_down (btn_thr_down),
        .sw_grayscale (sw_grayscale),
        .sw_threshold (sw_threshold),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_blank_n  (vga_blank_n)
    );

    // ==============================
    // expected pixel model
    // ==============================
    function automatic logic [23:0] ref_rgb(input logic [15:0] pix, input logic gray_on,
                                            input logic thr_on, input int thr);
        int r;
        int g;
        int b;
        int y;
        r = int'({pix[15:11], 3'b111});   // 565 widened with ones below
        g = int'({pix[10:5], 2'b11});
        b = int'({pix[4:0], 3'b111});
        y = (GRAY_WR * r + GRAY_WG * g + GRAY_WB * b) >> 8;
        if (thr_on) begin
            y = (y >= thr) ? 255 : 0;
            return {8'(y), 8'(y), 8'(y)};
        end else if (gray_on) begin
            return {8'(y), 8'(y), 8'(y)};
        end
        return {8'(r), 8'(g), 8'(b)};
    endfunction

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d (line %0d, col %0d)",
                     $time, what, got, expected, pos_line, pos_col);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // ==============================
    // stimulus helpers
    // ==============================
    task automatic write_word(input int addr, input logic [15:0] data);
        @(posedge clk_25_vga);
        wr_addr <= ADDR_W'(addr);
        wr_data <= data;
        wr_req  <= 1'b1;
        shadow[addr] = data;
        do @(negedge clk_25_vga); while (!wr_ack);   // word taken
        @(posedge clk_25_vga);
        wr_req <= 1'b0;
        do @(negedge clk_25_vga); while (wr_ack);    // cycle closed
    endtask

    task automatic press_button(input logic up, input int hold);
        @(posedge clk_25_vga);
        if (up) begin
            btn_thr_up <= 1'b0;
        end else begin
            btn_thr_down <= 1'b0;
        end
        repeat (hold) @(posedge clk_25_vga);
        btn_thr_up   <= 1'b1;
        btn_thr_down <= 1'b1;
        repeat (DEBOUNCE_CYCLES + 2) @(posedge clk_25_vga);
        // one saturating step per press however long the hold
        if (up) begin
            thr_model = (thr_model + THR_STEP > THR_MAX) ? THR_MAX : thr_model + THR_STEP;
        end else begin
            thr_model = (thr_model < THR_STEP) ? 0 : thr_model - THR_STEP;
        end
    endtask

    task automatic wait_vblank();
        @(negedge vga_vsync);   // sync pulse at the pins lies well inside blanking
    endtask

    // ==============================
    // compare process
    // ==============================
    always @(negedge clk_25_vga) begin
        if (rst_n) begin
            cyc = cyc + 1;
            if (!vga_hsync && hs_prev) begin
                if (hs_last >= 0) check_value("hsync period", cyc - hs_last, H_TOTAL);
                hs_last = cyc;
            end
            hs_prev = vga_hsync;
            if (vga_blank_n) begin
                exp_rgb = 24'h0;                                   // dark unless shown
                if (exp_on) begin
                    exp_rgb = ref_rgb(shadow[(pos_line / 2) * FB_WIDTH + pos_col / 2],
                                      sw_grayscale, sw_threshold, thr_model);
                    lit_checked = lit_checked + 1;
                end
                check_value("red", int'(vga_r), int'(exp_rgb[23:16]));
                check_value("green", int'(vga_g), int'(exp_rgb[15:8]));
                check_value("blue", int'(vga_b), int'(exp_rgb[7:0]));
                pos_col = pos_col + 1;
            end else begin
                check_value("red in blanking", int'(vga_r), 0);
                check_value("green in blanking", int'(vga_g), 0);
                check_value("blue in blanking", int'(vga_b), 0);
                if (blank_prev) begin                              // end of an active line
                    check_value("pixels per line", pos_col, H_ACTIVE);
                    pos_line = pos_line + 1;
                    pos_col  = 0;
                end
            end
            blank_prev = vga_blank_n;
            if (!vga_vsync && vs_prev) begin
                check_value("lines per frame", pos_line, V_ACTIVE);
                if (vs_last >= 0) check_value("vsync period", cyc - vs_last, FRAME_CLKS);
                vs_last  = cyc;
                pos_line = 0;
            end
            vs_prev = vga_vsync;
        end
    end

    // watchdog covers seven frames plus the load
    initial begin
        repeat (WATCHDOG_CLK) @(posedge clk_25_vga);
        $display("Timeout: the run did not finish within %0d clocks", WATCHDOG_CLK);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    // ==============================
    // scenarios
    // ==============================
    initial begin
        void'($urandom(RAND_SEED));
        rst_n        = 1'b0;
        wr_req       = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        frame_valid  = 1'b0;
        btn_thr_up   = 1'b1;   // buttons idle high
        btn_thr_down = 1'b1;
        sw_grayscale = 1'b0;
        sw_threshold = 1'b0;
        repeat (4) @(posedge clk_25_vga);
        rst_n <= 1'b1;

        // frame 0 scans dark while the whole buffer is loaded into both banks
        for (int a = 0; a < FB_PIXELS; a++) begin
            write_word(a, 16'($urandom));
        end

        wait_vblank();
        @(posedge clk_25_vga);
        frame_valid <= 1'b1;        // armed while frame 1 stays dark
        wait_vblank();
        exp_on = 1'b1;              // video on since this vsync so frame 2 shows colour
        wait_vblank();
        @(posedge clk_25_vga);
        sw_grayscale <= 1'b1;       // frame 3 gray
        wait_vblank();
        @(posedge clk_25_vga);
        sw_threshold <= 1'b1;       // wins over gray
        repeat (4) press_button(1'b1, DEBOUNCE_CYCLES + 4);
        press_button(1'b1, 64 * DEBOUNCE_CYCLES);   // long hold still gives one step
        wait_vblank();
        repeat (19) press_button(1'b0, DEBOUNCE_CYCLES + 4);   // runs into 0
        wait_vblank();
        @(posedge clk_25_vga);
        frame_valid <= 1'b0;        // frame 6 back to dark
        exp_on = 1'b0;
        wait_vblank();

        if (lit_checked == LIT_FRAMES * H_ACTIVE * V_ACTIVE) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Wrong number of shown pixels compared: %0d", lit_checked);
            $display("RESULT: FAIL");
            $fatal(1, "picture frames missing");
        end
    end

endmodule

//--- cam_display_top.sv
`timescale 1ns/1ps

module cam_display_top (
    input  logic                                clk_25_vga,
    input  logic                                rst_n,
    // writer port
    input  logic                                wr_req,
    input  logic [cam_display_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [cam_display_pkg::PIX_W-1:0]   wr_data,
    output logic                                wr_ack,
    input  logic                                frame_valid,
    // board controls
    input  logic                                btn_thr_up,
    input  logic                                btn_thr_down,
    input  logic                                sw_grayscale,
    input  logic                                sw_threshold,
    // vga pins
    output logic [cam_display_pkg::COLOR_W-1:0] vga_r,
    output logic [cam_display_pkg::COLOR_W-1:0] vga_g,
    output logic [cam_display_pkg::COLOR_W-1:0] vga_b,
    output logic                                vga_hsync,
    output logic                                vga_vsync,
    output logic                                vga_blank_n
);
    import cam_display_pkg::*;

    logic [ADDR_W-1:0]  rd_addr;
    logic [PIX_W-1:0]   rd_data;
    logic               active;
    logic               hsync;
    logic               vsync;
    logic               frame_start;
    logic               video_en;
    logic [COLOR_W-1:0] threshold;

    vga_timing vga_timing_inst (
        .clk_25_vga  (clk_25_vga),
        .rst_n       (rst_n),
        .hsync       (hsync),
        .vsync       (vsync),
        .active      (active),
        .frame_start (frame_start),
        .rd_addr     (rd_addr)
    );

    display_ctrl display_ctrl_inst (
        .clk_25_vga  (clk_25_vga),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frame_start (frame_start),
        .video_en    (video_en)
    );

    frame_buffer frame_buffer_inst (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_ack     (wr_ack),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    threshold_ctrl threshold_ctrl_inst (
        .clk_25_vga   (clk_25_vga),
        .rst_n        (rst_n),
        .btn_thr_up   (btn_thr_up),
        .btn_thr_down (btn_thr_down),
        .threshold    (threshold)
    );

    pixel_path pixel_path_inst (
        .clk_25_vga   (clk_25_vga),
        .rst_n        (rst_n),
        .rd_data      (rd_data),
        .active       (active),
        .hsync        (hsync),
        .vsync        (vsync),
        .video_en     (video_en),
        .sw_grayscale (sw_grayscale),
        .sw_threshold (sw_threshold),
        .threshold    (threshold),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_blank_n  (vga_blank_n)
    );

endmodule

//--- pixel_path.sv
`timescale 1ns/1ps

module pixel_path (
    input  logic                                clk_25_vga,
    input  logic                                rst_n,
    input  logic [cam_display_pkg::PIX_W-1:0]   rd_data,
    input  logic                                active,
    input  logic                                hsync,
    input  logic                                vsync,
    input  logic                                video_en,
    input  logic                                sw_grayscale,
    input  logic                                sw_threshold,
    input  logic [cam_display_pkg::COLOR_W-1:0] threshold,
    output logic [cam_display_pkg::COLOR_W-1:0] vga_r,
    output logic [cam_display_pkg::COLOR_W-1:0] vga_g,
    output logic [cam_display_pkg::COLOR_W-1:0] vga_b,
    output logic                                vga_hsync,
    output logic                                vga_vsync,
    output logic                                vga_blank_n
);
    import cam_display_pkg::*;

    logic [RD_LAT-1:0]    active_sr;   // timing delayed to match the buffer
    logic [RD_LAT-1:0]    hsync_sr;
    logic [RD_LAT-1:0]    vsync_sr;
    logic [COLOR_W-1:0]   r8, g8, b8;
    logic [2*COLOR_W-1:0] gray_sum;
    logic [COLOR_W-1:0]   gray;
    logic [COLOR_W-1:0]   bin;
    logic [COLOR_W-1:0]   sel_r, sel_g, sel_b;
    logic                 show;

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            active_sr <= '0;
            hsync_sr  <= '1;        // syncs idle high
            vsync_sr  <= '1;
        end else begin
            active_sr <= {active_sr[RD_LAT-2:0], active};
            hsync_sr  <= {hsync_sr[RD_LAT-2:0], hsync};
            vsync_sr  <= {vsync_sr[RD_LAT-2:0], vsync};
        end
    end

    // rgb565 to rgb888, low bits set
    assign r8 = {rd_data[15:11], 3'b111};
    assign g8 = {rd_data[10:5], 2'b11};
    assign b8 = {rd_data[4:0], 3'b111};

    assign gray_sum = (2*COLOR_W)'(GRAY_WR * r8 + GRAY_WG * g8 + GRAY_WB * b8);
    assign gray     = gray_sum[2*COLOR_W-1:COLOR_W];   // >> 8
    assign bin      = (gray >= threshold) ? '1 : '0;

    // priority threshold, gray, colour
    always_comb begin
        if (sw_threshold) begin
            sel_r = bin;
            sel_g = bin;
            sel_b = bin;
        end else if (sw_grayscale) begin
            sel_r = gray;
            sel_g = gray;
            sel_b = gray;
        end else begin
            sel_r = r8;
            sel_g = g8;
            sel_b = b8;
        end
    end

    assign show = video_en && active_sr[RD_LAT-1];

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
            vga_hsync   <= 1'b1;
            vga_vsync   <= 1'b1;
            vga_blank_n <= 1'b0;
        end else begin
            vga_r       <= show ? sel_r : '0;   // black outside picture
            vga_g       <= show ? sel_g : '0;
            vga_b       <= show ? sel_b : '0;
            vga_hsync   <= hsync_sr[RD_LAT-1];
            vga_vsync   <= vsync_sr[RD_LAT-1];
            vga_blank_n <= active_sr[RD_LAT-1];
        end
    end

    // pins trail the counter decode by the full pipe depth
    a_sync_align: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        $past(rst_n, PIPE_LAT) |-> (vga_hsync == $past(hsync, PIPE_LAT)) &&
                                   (vga_vsync == $past(vsync, PIPE_LAT)) &&
                                   (vga_blank_n == $past(active, PIPE_LAT)));

endmodule

//--- threshold_ctrl.sv
`timescale 1ns/1ps

module threshold_ctrl (
    input  logic                                clk_25_vga,
    input  logic                                rst_n,
    input  logic                                btn_thr_up,    // active low
    input  logic                                btn_thr_down,  // active low
    output logic [cam_display_pkg::COLOR_W-1:0] threshold
);
    import cam_display_pkg::*;

    logic [1:0]          btn_low;     // bit 0 up, bit 1 down
    logic [DB_CNT_W-1:0] db_cnt [2];  // low time so far
    logic [1:0]          stable;      // debounced press
    logic [1:0]          stable_d;
    logic [1:0]          step;        // one clock per press

    assign btn_low = {~btn_thr_down, ~btn_thr_up};

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            db_cnt[0] <= '0;
            db_cnt[1] <= '0;
            stable    <= '0;
            stable_d  <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!btn_low[i]) begin
                    db_cnt[i] <= '0;             // released, start over
                    stable[i] <= 1'b0;
                end else if (!stable[i]) begin
                    if (db_cnt[i] == DB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                        stable[i] <= 1'b1;
                    end else begin
                        db_cnt[i] <= db_cnt[i] + 1'b1;
                    end
                end
            end
            stable_d <= stable;
        end
    end

    assign step = stable & ~stable_d;  // rising edge only, holding does not repeat

    // saturating steps, down wins a tie
    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            threshold <= COLOR_W'(THR_INIT);
        end else if (step[1]) begin
            threshold <= (threshold <= COLOR_W'(THR_STEP)) ? '0
                                                          : threshold - COLOR_W'(THR_STEP);
        end else if (step[0]) begin
            threshold <= (threshold >= COLOR_W'(THR_MAX - THR_STEP)) ? COLOR_W'(THR_MAX)
                                                                    : threshold + COLOR_W'(THR_STEP);
        end
    end

endmodule

//--- frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
    input  logic                               clk_25_vga,
    input  logic                               rst_n,
    input  logic                               wr_req,
    input  logic [cam_display_pkg::ADDR_W-1:0] wr_addr,
    input  logic [cam_display_pkg::PIX_W-1:0]  wr_data,
    output logic                               wr_ack,
    input  logic [cam_display_pkg::ADDR_W-1:0] rd_addr,
    output logic [cam_display_pkg::PIX_W-1:0]  rd_data
);
    import cam_display_pkg::*;

    logic [PIX_W-1:0] bank0 [0:BANK_SPLIT-1];              // words 0 .. 32767
    logic [PIX_W-1:0] bank1 [0:FB_PIXELS-BANK_SPLIT-1];    // words 32768 .. 76799

    logic                          wr_fire;   // one write per request
    logic                          wr_hi;     // target in bank 1
    logic [$clog2(BANK_SPLIT)-1:0] wr_off0;
    logic [BANK_ADDR_W-1:0]        wr_off1;

    logic                          rd_hi_q;
    logic                          rd_hi_qq;
    logic [$clog2(BANK_SPLIT)-1:0] rd_off0_q;
    logic [BANK_ADDR_W-1:0]        rd_off1_q;
    logic [PIX_W-1:0]              bank0_q;
    logic [PIX_W-1:0]              bank1_q;

    // ==============================
    // write port, four-phase slave
    // ==============================
    assign wr_fire = wr_req && !wr_ack;
    assign wr_hi   = (wr_addr >= ADDR_W'(BANK_SPLIT));
    assign wr_off0 = wr_addr[$clog2(BANK_SPLIT)-1:0];
    assign wr_off1 = BANK_ADDR_W'(wr_addr - ADDR_W'(BANK_SPLIT));

    always_ff @(posedge clk_25_vga) begin
        if (wr_fire && !wr_hi) begin
            bank0[wr_off0] <= wr_data;
        end
        if (wr_fire && wr_hi) begin
            bank1[wr_off1] <= wr_data;
        end
    end

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            wr_ack <= 1'b0;
        end else if (wr_fire) begin
            wr_ack <= 1'b1;          // word is in, acknowledge
        end else if (!wr_req) begin
            wr_ack <= 1'b0;          // request released, close the cycle
        end
    end

    // ==============================
    // read path, three stages
    // ==============================
    always_ff @(posedge clk_25_vga) begin
        rd_hi_q   <= (rd_addr >= ADDR_W'(BANK_SPLIT));          // stage 1, split
        rd_off0_q <= rd_addr[$clog2(BANK_SPLIT)-1:0];
        rd_off1_q <= BANK_ADDR_W'(rd_addr - ADDR_W'(BANK_SPLIT));
        bank0_q   <= bank0[rd_off0_q];                          // stage 2, bank reads
        bank1_q   <= bank1[rd_off1_q];
        rd_hi_qq  <= rd_hi_q;
        rd_data   <= rd_hi_qq ? bank1_q : bank0_q;              // stage 3, bank mux
    end

    // request held until acknowledged
    a_req_held: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        (wr_req && !wr_ack) |=> wr_req);

    a_wr_range: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        wr_req |-> (wr_addr < ADDR_W'(FB_PIXELS)));

endmodule

//--- display_ctrl.sv
`timescale 1ns/1ps

module display_ctrl (
    input  logic clk_25_vga,
    input  logic rst_n,
    input  logic frame_valid,
    input  logic frame_start,
    output logic video_en
);
    import cam_display_pkg::*;

    logic [1:0] state;
    logic [1:0] state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (frame_valid && frame_start) begin
                    state_nxt = ST_SHOW;   // frame ready right at vsync
                end else if (frame_valid) begin
                    state_nxt = ST_ARMED;
                end
            end
            ST_ARMED: begin
                if (!frame_valid) begin
                    state_nxt = ST_IDLE;
                end else if (frame_start) begin
                    state_nxt = ST_SHOW;
                end
            end
            ST_SHOW: begin
                if (!frame_valid) begin
                    state_nxt = ST_IDLE;   // frame withdrawn so go dark
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            video_en <= 1'b0;
        end else begin
            state    <= state_nxt;
            video_en <= (state_nxt == ST_SHOW);
        end
    end

    // video only while a loaded frame is present and only entered on a vsync
    a_en_needs_valid: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        video_en |-> $past(frame_valid));

    a_en_at_vsync: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        $rose(video_en) |-> $past(frame_start && frame_valid));

endmodule

//--- vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic                               clk_25_vga,
    input  logic                               rst_n,
    output logic                               hsync,
    output logic                               vsync,
    output logic                               active,
    output logic                               frame_start,
    output logic [cam_display_pkg::ADDR_W-1:0] rd_addr
);
    import cam_display_pkg::*;

    logic [CNT_W-1:0]  h_cnt;     // column within the line
    logic [CNT_W-1:0]  v_cnt;     // line within the frame
    logic [ADDR_W-1:0] row_base;  // (v_cnt/2) * FB_WIDTH, built by adding
    logic              line_end;

    assign line_end = (h_cnt == CNT_W'(H_TOTAL - 1));

    always_ff @(posedge clk_25_vga) begin
        if (!rst_n) begin
            h_cnt    <= '0;
            v_cnt    <= '0;
            row_base <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            if (v_cnt == CNT_W'(V_TOTAL - 1)) begin
                v_cnt    <= '0;
                row_base <= '0;                          // back to stored row 0
            end else begin
                v_cnt <= v_cnt + 1'b1;
                // every second visible line moves to the next stored row
                if (v_cnt[0] && (v_cnt < CNT_W'(V_ACTIVE))) begin
                    row_base <= row_base + ADDR_W'(FB_WIDTH);
                end
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // negative polarity syncs
    assign hsync = !((h_cnt >= CNT_W'(H_ACTIVE + H_FRONT)) &&
                     (h_cnt <  CNT_W'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign vsync = !((v_cnt >= CNT_W'(V_ACTIVE + V_FRONT)) &&
                     (v_cnt <  CNT_W'(V_ACTIVE + V_FRONT + V_SYNC)));
    assign active = (h_cnt < CNT_W'(H_ACTIVE)) && (v_cnt < CNT_W'(V_ACTIVE));

    // one pulse, first clock of the vsync pulse
    assign frame_start = (h_cnt == '0) && (v_cnt == CNT_W'(V_ACTIVE + V_FRONT));

    assign rd_addr = row_base + ADDR_W'(h_cnt[CNT_W-1:1]);  // column halved

    // ==============================
    // checks
    // ==============================
    a_cnt_range: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        (h_cnt < CNT_W'(H_TOTAL)) && (v_cnt < CNT_W'(V_TOTAL)));

    a_rd_addr_range: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        active |-> (rd_addr < ADDR_W'(FB_PIXELS)));

endmodule

//--- cam_display_pkg.sv
package cam_display_pkg;

    // ==============================
    // vga 640x480 timing
    // ==============================
    localparam int H_ACTIVE = 640;          // clocks
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = 800;
    localparam int V_ACTIVE = 480;          // lines
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = 525;
    localparam int CNT_W    = 10;           // fits both h and v counters

    // ==============================
    // stored frame, rgb565
    // ==============================
    localparam int FB_WIDTH    = 320;
    localparam int FB_HEIGHT   = 240;
    localparam int FB_PIXELS   = FB_WIDTH * FB_HEIGHT;
    localparam int ADDR_W      = 17;
    localparam int BANK_SPLIT  = 32768;     // first word of bank 1
    localparam int BANK_ADDR_W = 16;
    localparam int PIX_W       = 16;
    localparam int COLOR_W     = 8;

    // luma weights, sum is divided by 256
    localparam int GRAY_WR = 76;
    localparam int GRAY_WG = 150;
    localparam int GRAY_WB = 26;

    // binary threshold control
    localparam int THR_INIT        = 64;
    localparam int THR_STEP        = 5;
    localparam int THR_MAX         = 255;
    localparam int DEBOUNCE_CYCLES = 16;
    localparam int DB_CNT_W        = $clog2(DEBOUNCE_CYCLES);

    // latencies
    localparam int RD_LAT   = 3;            // rd_addr to rd_data
    localparam int PIPE_LAT = RD_LAT + 1;   // counters to pins

    // display fsm encodings
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ARMED = 2'd1;
    localparam logic [1:0] ST_SHOW  = 2'd2;

endpackage
